// File: hw/bootrom.sv
// Read-only boot memory with a registered read
// The word index wraps modulo the table size
`include "mempool_settings.svh"

module bootrom (
  input  logic               clk_i,
  input  logic               req_i,
  input  mempool_pkg::addr_t addr_i,
  output mempool_pkg::data_t rdata_o
);
  import mempool_pkg::*;

  localparam int    NUM_WORDS = `MEMPOOL_BOOTROM_WORDS;
  localparam int    IDX_WIDTH = $clog2(NUM_WORDS);
  localparam data_t TABLE [NUM_WORDS] = `MEMPOOL_BOOTROM_TABLE;

  logic [IDX_WIDTH-1:0] word_idx;
  data_t                rdata_q;

  assign word_idx = addr_i[IDX_WIDTH+BYTE_OFF_WIDTH-1:BYTE_OFF_WIDTH]; // Byte offset dropped

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= TABLE[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule : bootrom

// File: hw/ctrl_registers.sv
// Control registers: EOC, wake-up, TCDM start, core count and scratch words
// Byte enables are ignored and the low two address bits are not decoded
`include "mempool_settings.svh"

module ctrl_registers (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  mempool_pkg::addr_t            addr_i,
  input  mempool_pkg::data_t            wdata_i,
  output mempool_pkg::data_t            rdata_o,
  output logic                          err_o,
  output logic                          eoc_valid_o,
  output logic [`MEMPOOL_NUM_CORES-1:0] wake_up_o
);
  import mempool_pkg::*;

  localparam int NUM_CORES = `MEMPOOL_NUM_CORES;
  localparam int CORE_W    = $clog2(NUM_CORES);
  localparam int OFF_W     = $clog2(`MEMPOOL_CTRL_SIZE) - BYTE_OFF_WIDTH; // Word offset bits
  localparam int SCR_W     = $clog2(`MEMPOOL_NUM_SCRATCH);

  localparam logic [OFF_W-1:0] EOC_W   = OFF_W'(`MEMPOOL_REG_EOC >> BYTE_OFF_WIDTH);
  localparam logic [OFF_W-1:0] WAKE_W  = OFF_W'(`MEMPOOL_REG_WAKE_UP >> BYTE_OFF_WIDTH);
  localparam logic [OFF_W-1:0] TCDM_W  = OFF_W'(`MEMPOOL_REG_TCDM_START >> BYTE_OFF_WIDTH);
  localparam logic [OFF_W-1:0] CORES_W = OFF_W'(`MEMPOOL_REG_NUM_CORES >> BYTE_OFF_WIDTH);
  localparam logic [OFF_W-1:0] SCR_W0  = OFF_W'(`MEMPOOL_REG_SCRATCH >> BYTE_OFF_WIDTH);

  logic [OFF_W-1:0]     word_off, scr_off;
  logic [SCR_W-1:0]     scr_idx;
  logic                 is_scratch, bad_off, ro_reg, err_d;
  data_t                rdata_d, rdata_q;
  data_t                eoc_q;
  data_t                scratch_q [`MEMPOOL_NUM_SCRATCH];
  logic [NUM_CORES-1:0] wake_up_d, wake_up_q;
  logic                 err_q;

  assign word_off   = addr_i[OFF_W+BYTE_OFF_WIDTH-1:BYTE_OFF_WIDTH];
  assign scr_off    = word_off - SCR_W0;
  assign scr_idx    = scr_off[SCR_W-1:0];
  assign is_scratch = (word_off >= SCR_W0) && (scr_off < OFF_W'(`MEMPOOL_NUM_SCRATCH));

  // Read mux and offset check
  always_comb begin
    rdata_d = '0;
    bad_off = 1'b0;
    ro_reg  = 1'b0;
    if (is_scratch) begin
      rdata_d = scratch_q[scr_idx];
    end else begin
      case (word_off)
        EOC_W:   rdata_d = eoc_q;
        WAKE_W:  rdata_d = '0; // Write-only
        TCDM_W: begin
          rdata_d = `MEMPOOL_TCDM_BASE;
          ro_reg  = 1'b1;
        end
        CORES_W: begin
          rdata_d = data_t'(NUM_CORES);
          ro_reg  = 1'b1;
        end
        default: bad_off = 1'b1;
      endcase
    end
  end

  assign err_d = bad_off || (we_i && ro_reg);

  // Core index wakes one core, all-ones wakes every core
  always_comb begin
    wake_up_d = '0;
    if (req_i && we_i && !is_scratch && word_off == WAKE_W) begin
      if (wdata_i == '1) begin
        wake_up_d = '1;
      end else if (wdata_i < data_t'(NUM_CORES)) begin
        wake_up_d[wdata_i[CORE_W-1:0]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
      err_q     <= 1'b0;
    end else begin
      wake_up_q <= wake_up_d; // Held for one cycle only
      err_q     <= req_i && err_d;
      if (req_i && we_i && !is_scratch && word_off == EOC_W) begin
        eoc_q <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rdata_d;
    end
    if (req_i && we_i && is_scratch) begin
      scratch_q[scr_idx] <= wdata_i;
    end
  end

  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

endmodule : ctrl_registers

// File: hw/l2_mem.sv
// Word-interleaved L2, one bank access per cycle and read data one cycle later
// Address bits above the L2 size are ignored, so accesses wrap
`include "mempool_settings.svh"

module l2_mem (
  input  logic               clk_i,
  input  logic               req_i,
  input  logic               we_i,
  input  mempool_pkg::addr_t addr_i,
  input  mempool_pkg::data_t wdata_i,
  input  mempool_pkg::strb_t strb_i,
  output mempool_pkg::data_t rdata_o
);
  import mempool_pkg::*;

  localparam int NUM_BANKS  = `MEMPOOL_NUM_L2_BANKS;
  localparam int BANK_WORDS = `MEMPOOL_L2_BANK_WORDS;

  l2_addr_u             addr;
  logic [NUM_BANKS-1:0] bank_req;
  data_t                bank_rdata [NUM_BANKS];
  bank_idx_t            bank_q;

  assign addr = addr_i;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_banks
    data_t mem [BANK_WORDS];
    data_t rdata_q;

    // Only the addressed bank is enabled
    assign bank_req[b] = req_i && (addr.bank.bank_idx == bank_idx_t'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req[b]) begin
        if (we_i) begin
          for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb_i[i]) begin
              mem[addr.bank.row][8*i +: 8] <= wdata_i[8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem[addr.bank.row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Bank of the last access, selects the returning word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      bank_q <= addr.bank.bank_idx;
    end
  end

  assign rdata_o = bank_rdata[bank_q];

endmodule : l2_mem

// File: hw/mempool_pkg.sv
// Shared types of the MemPool system, widths taken from the settings header
// The L2 address union assumes the L2 window is aligned to its own size
`include "mempool_settings.svh"

package mempool_pkg;

  localparam int ADDR_WIDTH     = `MEMPOOL_ADDR_WIDTH;
  localparam int DATA_WIDTH     = `MEMPOOL_DATA_WIDTH;
  localparam int STRB_WIDTH     = DATA_WIDTH / 8;
  localparam int L2_SIZE        = `MEMPOOL_NUM_L2_BANKS * `MEMPOOL_L2_BANK_WORDS * STRB_WIDTH;
  localparam int L2_OFF_WIDTH   = $clog2(L2_SIZE);
  localparam int BANK_IDX_WIDTH = $clog2(`MEMPOOL_NUM_L2_BANKS);
  localparam int BANK_ROW_WIDTH = $clog2(`MEMPOOL_L2_BANK_WORDS);
  localparam int BYTE_OFF_WIDTH = $clog2(STRB_WIDTH);

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef logic [BANK_IDX_WIDTH-1:0] bank_idx_t;
  typedef logic [BANK_ROW_WIDTH-1:0] bank_row_t;

  typedef enum logic [1:0] {
    REGION_NONE    = 2'd0, // Unmapped, answered with an error
    REGION_CTRL    = 2'd1,
    REGION_L2      = 2'd2,
    REGION_BOOTROM = 2'd3
  } region_e;

  // Window match and offset inside the L2
  typedef struct packed {
    logic [ADDR_WIDTH-L2_OFF_WIDTH-1:0] upper;
    logic [L2_OFF_WIDTH-1:0]            offset;
  } l2_region_view_t;

  // Word interleaving, consecutive words go to consecutive banks
  typedef struct packed {
    logic [ADDR_WIDTH-L2_OFF_WIDTH-1:0] unused;
    bank_row_t                          row;
    bank_idx_t                          bank_idx;
    logic [BYTE_OFF_WIDTH-1:0]          byte_off;
  } l2_bank_view_t;

  typedef union packed {
    l2_region_view_t region_off;
    l2_bank_view_t   bank;
  } l2_addr_u;

endpackage : mempool_pkg

// File: hw/mempool_settings.svh
// Address map, sizes and register offsets of the MemPool system
// Each window base must be aligned to its size, and the L2 bank count must be a power of two
`ifndef MEMPOOL_SETTINGS_SVH
`define MEMPOOL_SETTINGS_SVH

`define MEMPOOL_ADDR_WIDTH     32
`define MEMPOOL_DATA_WIDTH     32
`define MEMPOOL_NUM_CORES      16           // One wake-up line per core

// Interleaved L2
`define MEMPOOL_NUM_L2_BANKS   4
`define MEMPOOL_L2_BANK_WORDS  256
`define MEMPOOL_L2_BASE        32'h8000_0000

`define MEMPOOL_BOOTROM_BASE   32'hA000_0000
`define MEMPOOL_BOOTROM_WORDS  16

// Control register window
`define MEMPOOL_CTRL_BASE      32'h4000_0000
`define MEMPOOL_CTRL_SIZE      32'h0000_1000
`define MEMPOOL_TCDM_BASE      32'h0000_0000 // Reported, not decoded
`define MEMPOOL_NUM_SCRATCH    8

`define MEMPOOL_REG_EOC        32'h00
`define MEMPOOL_REG_WAKE_UP    32'h04
`define MEMPOOL_REG_TCDM_START 32'h08
`define MEMPOOL_REG_NUM_CORES  32'h0C
`define MEMPOOL_REG_SCRATCH    32'h10 // First of the scratch words

// Boot code, word 0 at the bootrom base
`define MEMPOOL_BOOTROM_TABLE '{ \
  32'hf140_2573, 32'h0000_0597, 32'h0405_8593, 32'h8000_02b7, \
  32'h0002_8067, 32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013, \
  32'h4000_0337, 32'h0003_2383, 32'h0013_f393, 32'hfe03_8ce3, \
  32'h0000_0013, 32'h0000_0013, 32'hdead_beef, 32'h600d_cafe  \
}

`endif

// File: hw/mempool_soc_router.sv
// Single-word request router, one request per cycle with no back-pressure
// Slaves must answer exactly one cycle after their select; unmapped and bootrom writes error
`include "mempool_settings.svh"

module mempool_soc_router (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  input  logic               req_we_i,
  input  mempool_pkg::addr_t req_addr_i,
  input  mempool_pkg::data_t req_wdata_i,
  input  mempool_pkg::strb_t req_strb_i,
  input  mempool_pkg::data_t l2_rdata_i,
  input  mempool_pkg::data_t rom_rdata_i,
  input  mempool_pkg::data_t ctrl_rdata_i,
  input  logic               ctrl_err_i,
  output logic               rsp_valid_o,
  output mempool_pkg::data_t rsp_rdata_o,
  output logic               rsp_err_o,
  output logic               l2_req_o,
  output logic               rom_req_o,
  output logic               ctrl_req_o,
  output logic               slv_we_o,
  output mempool_pkg::addr_t slv_addr_o,
  output mempool_pkg::data_t slv_wdata_o,
  output mempool_pkg::strb_t slv_strb_o
);
  import mempool_pkg::*;

  localparam addr_t L2_BASE   = `MEMPOOL_L2_BASE;
  localparam addr_t CTRL_BASE = `MEMPOOL_CTRL_BASE;
  localparam addr_t CTRL_END  = `MEMPOOL_CTRL_BASE + `MEMPOOL_CTRL_SIZE;
  localparam addr_t ROM_BASE  = `MEMPOOL_BOOTROM_BASE;
  localparam addr_t ROM_END   = `MEMPOOL_BOOTROM_BASE + `MEMPOOL_BOOTROM_WORDS * STRB_WIDTH;

  l2_addr_u req_addr;
  region_e  region_d, region_q;
  logic     wr_err_d, wr_err_q;
  logic     valid_q, we_q;

  assign req_addr = req_addr_i;

  always_comb begin
    region_d = REGION_NONE;
    if (req_addr.region_off.upper == L2_BASE[ADDR_WIDTH-1:L2_OFF_WIDTH]) begin
      region_d = REGION_L2;
    end else if (req_addr_i >= CTRL_BASE && req_addr_i < CTRL_END) begin
      region_d = REGION_CTRL;
    end else if (req_addr_i >= ROM_BASE && req_addr_i < ROM_END) begin
      region_d = REGION_BOOTROM;
    end
  end

  assign wr_err_d   = req_we_i && (region_d == REGION_BOOTROM); // ROM never sees a write
  assign l2_req_o   = req_valid_i && (region_d == REGION_L2);
  assign ctrl_req_o = req_valid_i && (region_d == REGION_CTRL);
  assign rom_req_o  = req_valid_i && (region_d == REGION_BOOTROM) && !req_we_i;

  // Request lines are shared by all slaves
  assign slv_we_o    = req_we_i;
  assign slv_addr_o  = req_addr_i;
  assign slv_wdata_o = req_wdata_i;
  assign slv_strb_o  = req_strb_i;

  // Remember who answers in the next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      wr_err_q <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      valid_q  <= req_valid_i;
      we_q     <= req_we_i;
      wr_err_q <= wr_err_d;
      region_q <= region_d;
    end
  end

  always_comb begin
    case (region_q)
      REGION_L2:      rsp_rdata_o = l2_rdata_i;
      REGION_CTRL:    rsp_rdata_o = ctrl_rdata_i;
      REGION_BOOTROM: rsp_rdata_o = rom_rdata_i;
      default:        rsp_rdata_o = '0;
    endcase
    if (!valid_q || we_q) rsp_rdata_o = '0; // Write responses carry no data
  end

  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = valid_q && ((region_q == REGION_NONE) || wr_err_q ||
                                   ((region_q == REGION_CTRL) && ctrl_err_i));

endmodule : mempool_soc_router

// File: hw/mempool_system.sv
// MemPool system without cluster: host port, router, L2, bootrom and control registers
// Every request is answered exactly one cycle later
`include "mempool_settings.svh"

module mempool_system (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_valid_i,
  input  logic                          req_we_i,
  input  mempool_pkg::addr_t            req_addr_i,
  input  mempool_pkg::data_t            req_wdata_i,
  input  mempool_pkg::strb_t            req_strb_i,
  output logic                          rsp_valid_o,
  output mempool_pkg::data_t            rsp_rdata_o,
  output logic                          rsp_err_o,
  output logic                          eoc_valid_o,
  output logic [`MEMPOOL_NUM_CORES-1:0] wake_up_o
);
  import mempool_pkg::*;

  // Router to slaves
  logic  l2_req, rom_req, ctrl_req;
  logic  slv_we;
  addr_t slv_addr;
  data_t slv_wdata;
  strb_t slv_strb;
  // Slaves to router
  data_t l2_rdata, rom_rdata, ctrl_rdata;
  logic  ctrl_err;

  mempool_soc_router router_inst (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i   ),
    .req_addr_i  (req_addr_i ),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i ),
    .l2_rdata_i  (l2_rdata   ),
    .rom_rdata_i (rom_rdata  ),
    .ctrl_rdata_i(ctrl_rdata ),
    .ctrl_err_i  (ctrl_err   ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o  ),
    .l2_req_o    (l2_req     ),
    .rom_req_o   (rom_req    ),
    .ctrl_req_o  (ctrl_req   ),
    .slv_we_o    (slv_we     ),
    .slv_addr_o  (slv_addr   ),
    .slv_wdata_o (slv_wdata  ),
    .slv_strb_o  (slv_strb   )
  );

  l2_mem l2_mem_inst (
    .clk_i  (clk_i    ),
    .req_i  (l2_req   ),
    .we_i   (slv_we   ),
    .addr_i (slv_addr ),
    .wdata_i(slv_wdata),
    .strb_i (slv_strb ),
    .rdata_o(l2_rdata )
  );

  bootrom bootrom_inst (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .addr_i (slv_addr ),
    .rdata_o(rom_rdata)
  );

  ctrl_registers ctrl_registers_inst (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (slv_we     ),
    .addr_i     (slv_addr   ),
    .wdata_i    (slv_wdata  ),
    .rdata_o    (ctrl_rdata ),
    .err_o      (ctrl_err   ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule : mempool_system

// File: run_sim.sh
#!/bin/sh
# Compiles the MemPool testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
  --top-module tb_mempool_system --Mdir obj_dir -o tb_mempool_system &&
  ./obj_dir/tb_mempool_system | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
  echo "run_sim: passed" ||
  { echo "run_sim: failed"; exit 1; }

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source, 20 ns period by default
// Reset is synchronous active low, released on a falling edge after RESET_CYCLES rising edges
module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1; // Release away from the sampling edge
  end

endmodule : tb_clock_gen

// File: sim/tb_mempool_system.sv
// Random and directed requests to the MemPool system are checked against a model
// L2 and scratch reads only hit locations written earlier in the run, as neither is reset
`include "mempool_settings.svh"

module tb_mempool_system;
  timeunit 1ns;
  timeprecision 1ps;
  import mempool_pkg::*;

  localparam int NUM_CORES  = `MEMPOOL_NUM_CORES;
  localparam int SCR_IDX_W  = $clog2(`MEMPOOL_NUM_SCRATCH);
  localparam int SEED       = 72;
  localparam int L2_WORDS   = L2_SIZE / 4; // Whole L2 window
  localparam int N_L2       = 400;
  localparam int N_ROM      = 40;
  localparam int N_MIXED    = 300;
  localparam int N_DIRECTED = 128; // Bound on control, wake-up and idle cycles
  localparam int TOTAL_REQS = L2_WORDS + N_L2 + N_ROM + N_MIXED + N_DIRECTED;
  localparam int TIMEOUT_NS = TOTAL_REQS * 20 * 2 + 1000;
  localparam data_t ROM_TABLE [`MEMPOOL_BOOTROM_WORDS] = `MEMPOOL_BOOTROM_TABLE;

  typedef logic [NUM_CORES-1:0] wake_t;
  typedef struct packed {
    logic [31:0] due; // Cycle in which the response is sampled
    data_t       rdata;
    logic        err;
    logic        eoc;
    wake_t       wake;
  } exp_rsp_t;

  logic  clk, rst_n;
  logic  req_valid, req_we;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_strb;
  logic  rsp_valid, rsp_err, eoc_valid;
  data_t rsp_rdata;
  wake_t wake_up;

  // Reference model
  logic [7:0]  l2_bytes [int unsigned];
  data_t       eoc_model;
  data_t       scratch_model [`MEMPOOL_NUM_SCRATCH];
  exp_rsp_t    exp_q [$];
  int unsigned cyc;
  logic        last_eoc;
  int          num_checks, num_errors, test_checks, test_errors;

  tb_clock_gen clock_gen_inst (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  mempool_system mempool_system_inst (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .req_valid_i(req_valid),
    .req_we_i   (req_we   ),
    .req_addr_i (req_addr ),
    .req_wdata_i(req_wdata),
    .req_strb_i (req_strb ),
    .rsp_valid_o(rsp_valid),
    .rsp_rdata_o(rsp_rdata),
    .rsp_err_o  (rsp_err  ),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up  )
  );

  task automatic check_data(input string name, input data_t exp, input data_t act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_wake(input wake_t exp, input wake_t act);
    num_checks++;
    if (act !== exp) begin
      num_errors++;
      $display("[ERROR] %0t ns wake_up_o expected %h actual %h", $time, exp, act);
    end
  endtask

  function automatic region_e decode_region(input addr_t addr);
    if (addr >= `MEMPOOL_L2_BASE && addr < `MEMPOOL_L2_BASE + L2_SIZE) return REGION_L2;
    if (addr >= `MEMPOOL_CTRL_BASE && addr < `MEMPOOL_CTRL_BASE + `MEMPOOL_CTRL_SIZE) begin
      return REGION_CTRL;
    end
    if (addr >= `MEMPOOL_BOOTROM_BASE && addr < `MEMPOOL_BOOTROM_BASE + 4 * 16) begin
      return REGION_BOOTROM;
    end
    return REGION_NONE;
  endfunction

  // Pulses one core by index, every core for all-ones and none for other values
  function automatic wake_t expected_wake(input data_t value);
    wake_t w;
    w = '0;
    if (value == '1) w = '1;
    else if (value < NUM_CORES) w = wake_t'(1) << value;
    return w;
  endfunction

  function automatic addr_t l2_word_addr(input int unsigned w);
    return `MEMPOOL_L2_BASE + 4 * (w % L2_WORDS);
  endfunction

  function automatic addr_t ctrl_addr(input addr_t off);
    return `MEMPOOL_CTRL_BASE + off;
  endfunction

  // Drives one request for one cycle and queues its expected response
  task automatic send_request(input logic we, input addr_t addr, input data_t wdata,
                              input strb_t strb);
    exp_rsp_t         e;
    l2_addr_u         la;
    addr_t            off;
    int unsigned      key;
    logic [SCR_IDX_W-1:0] idx;
    @(negedge clk);
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    req_strb  = strb;
    e.due   = cyc + 2;
    e.rdata = '0;
    e.err   = 1'b0;
    e.wake  = '0;
    la      = addr;
    off     = addr - `MEMPOOL_CTRL_BASE;
    case (decode_region(addr))
      REGION_L2: begin
        key = 32'({la.bank.row, la.bank.bank_idx}) * 4; // Byte offset bits ignored
        for (int i = 0; i < 4; i++) begin
          if (we && strb[i]) l2_bytes[key + i] = wdata[8*i +: 8];
          else if (!we) e.rdata[8*i +: 8] = l2_bytes[key + i];
        end
      end
      REGION_BOOTROM: begin
        if (we) e.err = 1'b1;
        else e.rdata = ROM_TABLE[addr[5:2]]; // Word index modulo 16
      end
      REGION_CTRL: begin
        if (off >= `MEMPOOL_REG_SCRATCH &&
            off < `MEMPOOL_REG_SCRATCH + 4 * `MEMPOOL_NUM_SCRATCH) begin
          idx = SCR_IDX_W'((off - `MEMPOOL_REG_SCRATCH) >> 2);
          if (we) scratch_model[idx] = wdata;
          else e.rdata = scratch_model[idx];
        end else begin
          case (off)
            `MEMPOOL_REG_EOC: begin
              if (we) eoc_model = wdata;
              else e.rdata = eoc_model;
            end
            `MEMPOOL_REG_WAKE_UP: begin
              if (we) e.wake = expected_wake(wdata); // Reads return zero
            end
            `MEMPOOL_REG_TCDM_START: begin
              if (we) e.err = 1'b1;
              else e.rdata = `MEMPOOL_TCDM_BASE;
            end
            `MEMPOOL_REG_NUM_CORES: begin
              if (we) e.err = 1'b1;
              else e.rdata = 32'(NUM_CORES);
            end
            default: e.err = 1'b1;
          endcase
        end
      end
      default: e.err = 1'b1; // Unmapped
    endcase
    if (we) e.rdata = '0;
    e.eoc = eoc_model[0];
    exp_q.push_back(e);
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk); // Catches late or extra responses
    $display("Test %s done: %0d checks, %0d errors", name, num_checks - test_checks,
             num_errors - test_errors);
    test_checks = num_checks;
    test_errors = num_errors;
  endtask

  // Checks responses, eoc and wake-up at every rising edge
  always @(posedge clk) begin
    exp_rsp_t e;
    logic     exp_eoc;
    wake_t    exp_wake;
    cyc = cyc + 1;
    if (rst_n) begin
      exp_eoc  = last_eoc;
      exp_wake = '0;
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e        = exp_q.pop_front();
        exp_eoc  = e.eoc;
        exp_wake = e.wake;
        last_eoc = e.eoc;
        if (!rsp_valid) begin
          num_errors++;
          $display("%0t ns: no response one cycle after the request", $time);
        end else begin
          check_flag("rsp_err_o", e.err, rsp_err);
          check_data("rsp_rdata_o", e.rdata, rsp_rdata);
        end
      end else if (rsp_valid) begin
        num_errors++;
        $display("%0t ns: response without a request in the cycle before", $time);
      end
      check_flag("eoc_valid_o", exp_eoc, eoc_valid);
      check_wake(exp_wake, wake_up);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    addr_t addr;
    req_valid   = 1'b0;
    req_we      = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    req_strb    = '0;
    cyc         = 0;
    last_eoc    = 1'b0;
    eoc_model   = '0;
    num_checks  = 0;
    num_errors  = 0;
    test_checks = 0;
    test_errors = 0;
    void'($urandom(SEED));
    @(posedge rst_n);

    finish_test("reset_idle");

    // Preload the window so every later read is known
    for (int i = 0; i < L2_WORDS; i++) send_request(1'b1, l2_word_addr(i), $urandom, '1);
    for (int i = 0; i < N_L2; i++) begin
      send_request(1'($urandom), l2_word_addr($urandom), $urandom, strb_t'($urandom));
    end
    finish_test("l2_random");

    for (int i = 0; i < N_ROM; i++) begin
      send_request($urandom % 4 == 0, `MEMPOOL_BOOTROM_BASE + 4 * ($urandom % 16), $urandom,
                   strb_t'($urandom));
    end
    finish_test("bootrom");

    for (int k = 0; k < `MEMPOOL_NUM_SCRATCH; k++) begin
      send_request(1'b1, ctrl_addr(`MEMPOOL_REG_SCRATCH + 4 * k), $urandom, '1);
    end
    for (int k = 0; k < `MEMPOOL_NUM_SCRATCH; k++) begin
      send_request(1'b0, ctrl_addr(`MEMPOOL_REG_SCRATCH + 4 * k), '0, '1);
    end
    send_request(1'b0, ctrl_addr(`MEMPOOL_REG_TCDM_START), '0, '1);
    send_request(1'b0, ctrl_addr(`MEMPOOL_REG_NUM_CORES), '0, '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_TCDM_START), $urandom, '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_NUM_CORES), $urandom, '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_EOC), 32'h1, '1);
    send_request(1'b0, ctrl_addr(`MEMPOOL_REG_EOC), '0, '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_EOC), 32'h2, '1); // Bit 0 clear
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_EOC), 32'h3, '1);
    send_request(1'b0, ctrl_addr(`MEMPOOL_REG_EOC), '0, '1);
    send_request(1'b0, ctrl_addr(32'h30), '0, '1);
    send_request(1'b1, ctrl_addr(32'h100), $urandom, '1);
    send_request(1'b0, ctrl_addr(32'hFFC), '0, '1);
    finish_test("ctrl_registers");

    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_WAKE_UP), $urandom % NUM_CORES, '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_WAKE_UP), '1, '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_WAKE_UP), 32'(NUM_CORES), '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_WAKE_UP), 32'h1234_5678, '1);
    send_request(1'b0, ctrl_addr(`MEMPOOL_REG_WAKE_UP), '0, '1);
    send_request(1'b1, ctrl_addr(`MEMPOOL_REG_WAKE_UP), 32'(NUM_CORES - 1), '1);
    finish_test("wake_up");

    for (int i = 0; i < N_MIXED; i++) begin
      case ($urandom % 4)
        0: addr = l2_word_addr($urandom);
        1: addr = `MEMPOOL_BOOTROM_BASE + 4 * ($urandom % 16);
        2: addr = ctrl_addr(4 * ($urandom % 16)); // Upper four words are bad offsets
        default: addr = 32'hC000_0000 | ($urandom & 32'h3FFF_FFFC); // Unmapped
      endcase
      send_request(1'($urandom), addr, $urandom, strb_t'($urandom));
    end
    finish_test("mixed_random");

    $display("All tests done: %0d checks, %0d errors", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_mempool_system

// File: sources.f
+incdir+hw
hw/mempool_pkg.sv
hw/mempool_soc_router.sv
hw/l2_mem.sv
hw/bootrom.sv
hw/ctrl_registers.sv
hw/mempool_system.sv
sim/tb_clock_gen.sv
sim/tb_mempool_system.sv
